// ==== logic/gcm_pkg.sv ====
package gcm_pkg;

    // ------------------------------
    // Block level types
    // ------------------------------
    typedef logic [127:0] block_t;
    typedef logic [15:0]  keep_t;
    typedef logic [63:0]  len_t;

    typedef enum logic [2:0] {
        phase_idle,
        phase_aad,
        phase_payload,
        phase_len,
        phase_wait,
        phase_done
    } phase_t;

    // ------------------------------
    // GHASH stepping
    // ------------------------------
    localparam int GHASH_BITS_PER_CYCLE = 8;
    localparam int GHASH_CYCLES         = 128 / GHASH_BITS_PER_CYCLE;

    // x^128 + x^7 + x^2 + x + 1 in the reflected GCM bit order
    localparam block_t GHASH_R = {8'he1, 120'h0};

    // Clear every byte whose keep bit is low, byte i sits at bits [8i+7:8i]
    function automatic block_t mask_block(block_t data, keep_t keep);
        block_t res;
        res = '0;
        for (int idx = 0; idx < 16; idx++) begin
            if (keep[idx]) begin
                res[idx*8 +: 8] = data[idx*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

// ==== logic/ghash_mult.sv ====
module ghash_mult (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            init,
    input  gcm_pkg::block_t hash_key,
    input  logic            mul_valid,
    input  gcm_pkg::block_t mul_block,
    output logic            mul_ready,
    output logic            mul_done,
    output gcm_pkg::block_t acc
);
    import gcm_pkg::*;

    block_t h_q;
    block_t x_q;
    block_t v_q;
    block_t z_q;
    block_t z_step;
    block_t v_step;
    logic   busy;
    logic   take;
    logic   last_step;
    logic [$clog2(GHASH_CYCLES)-1:0] step_cnt;

    assign mul_ready = !busy;
    assign take      = mul_valid && mul_ready;
    assign last_step = busy && (int'(step_cnt) == GHASH_CYCLES - 1);

    // ------------------------------
    // One slice of the shift-and-add product
    // ------------------------------
    // Operand bit 127 is the x^0 coefficient, so the slice is taken from the top
    always_comb begin
        z_step = z_q;
        v_step = v_q;
        for (int i = 0; i < GHASH_BITS_PER_CYCLE; i++) begin
            if (x_q[127 - i]) begin
                z_step = z_step ^ v_step;
            end
            if (v_step[0]) begin
                v_step = (v_step >> 1) ^ GHASH_R;
            end else begin
                v_step = v_step >> 1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            mul_done <= 1'b0;
            step_cnt <= '0;
        end else if (init) begin
            busy     <= 1'b0;
            mul_done <= 1'b0;
            step_cnt <= '0;
        end else begin
            mul_done <= 1'b0;
            if (take) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // Operand, multiplicand and partial product
    always_ff @(posedge clk) begin
        if (init) begin
            h_q <= hash_key;
            acc <= '0;
        end else if (take) begin
            x_q <= acc ^ mul_block;
            v_q <= h_q;
            z_q <= '0;
        end else if (busy) begin
            x_q <= x_q << GHASH_BITS_PER_CYCLE;
            v_q <= v_step;
            z_q <= z_step;
            if (last_step) begin
                acc <= z_step;
            end
        end
    end

    // The sequencer only offers a block once the multiplier is free
    a_valid_needs_ready: assert property (
        @(posedge clk) disable iff (!rst_n) mul_valid |-> mul_ready
    );

endmodule

// ==== logic/payload_ctr.sv ====
module payload_ctr (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            enc_mode,
    input  logic            pld_open,
    input  logic            din_valid,
    output logic            din_ready,
    input  logic            din_last,
    input  gcm_pkg::block_t din_data,
    input  gcm_pkg::keep_t  din_keep,
    input  gcm_pkg::block_t ks_data,
    output logic            dout_valid,
    input  logic            dout_ready,
    output logic            dout_last,
    output gcm_pkg::block_t dout_data,
    output gcm_pkg::keep_t  dout_keep,
    output logic            hash_valid,
    output gcm_pkg::block_t hash_block,
    output logic            hash_last,
    input  logic            hash_take
);
    import gcm_pkg::*;

    logic   mode_enc;
    logic   din_fire;
    logic   dout_fire;
    block_t xor_masked;
    block_t plain_masked;

    assign xor_masked   = mask_block(din_data ^ ks_data, din_keep);
    assign plain_masked = mask_block(din_data, din_keep);

    // Accept only when both the output slot and the hash slot are free
    assign din_ready = pld_open && !dout_valid && !hash_valid;
    assign din_fire  = din_valid && din_ready;
    assign dout_fire = dout_valid && dout_ready;

    // Mode is frozen while the payload window is open
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_enc <= 1'b1;
        end else if (!pld_open) begin
            mode_enc <= enc_mode;
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_valid <= 1'b0;
        end else if (din_fire) begin
            dout_valid <= 1'b1;
        end else if (dout_fire) begin
            dout_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (din_fire) begin
            dout_data <= xor_masked;
            dout_keep <= din_keep;
            dout_last <= din_last;
        end
    end

    // ------------------------------
    // Hash buffer
    // ------------------------------
    // GHASH always runs over ciphertext, whichever direction we go
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hash_valid <= 1'b0;
        end else if (din_fire) begin
            hash_valid <= 1'b1;
        end else if (hash_take) begin
            hash_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (din_fire) begin
            hash_block <= mode_enc ? xor_masked : plain_masked;
            hash_last  <= din_last;
        end
    end

    a_take_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) hash_take |-> hash_valid
    );

    a_dout_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        dout_valid && !dout_ready |=> dout_valid && $stable(dout_data)
    );

endmodule

// ==== logic/gcm_sequencer.sv ====
module gcm_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  gcm_pkg::len_t   len_aad_bits,
    input  gcm_pkg::len_t   len_pld_bits,
    input  logic            aad_valid,
    output logic            aad_ready,
    input  logic            aad_last,
    input  gcm_pkg::block_t aad_data,
    input  gcm_pkg::keep_t  aad_keep,
    output logic            pld_open,
    input  logic            hash_valid,
    input  gcm_pkg::block_t hash_block,
    input  logic            hash_last,
    output logic            hash_take,
    input  logic            dout_valid,
    output logic            init,
    output logic            mul_valid,
    output gcm_pkg::block_t mul_block,
    input  logic            mul_ready,
    input  logic            mul_done,
    input  gcm_pkg::block_t acc,
    output gcm_pkg::block_t tag_pre_xor,
    output logic            tag_pre_xor_valid,
    output logic            aad_done,
    output logic            pld_done,
    output logic            lens_done
);
    import gcm_pkg::*;

    logic   start_d;
    logic   start_pulse;
    logic   feed_ok;
    logic   aad_last_fire;
    logic   len_fire;
    logic   pld_drained;
    len_t   len_aad_q;
    len_t   len_pld_q;
    phase_t phase;
    phase_t phase_next;

    assign start_pulse = start && !start_d;
    assign init        = start_pulse;

    // A restart wins over any block offered in the same cycle
    assign feed_ok = mul_ready && !start_pulse;

    assign aad_ready     = (phase == phase_aad) && feed_ok;
    assign aad_last_fire = aad_valid && aad_ready && aad_last;
    assign pld_open      = (phase == phase_payload);
    assign len_fire      = (phase == phase_len) && mul_valid;

    // Last block hashed, nothing left on the output and the multiplier idle
    assign pld_drained = pld_done && !hash_valid && !dout_valid && mul_ready;

    // ------------------------------
    // Start edge and length latch
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d   <= 1'b0;
            len_aad_q <= '0;
            len_pld_q <= '0;
        end else begin
            start_d <= start;
            if (start_pulse) begin
                len_aad_q <= len_aad_bits;
                len_pld_q <= len_pld_bits;
            end
        end
    end

    // ------------------------------
    // GHASH input routing
    // ------------------------------
    always_comb begin
        mul_valid = 1'b0;
        mul_block = '0;
        hash_take = 1'b0;
        case (phase)
            phase_aad: begin
                mul_valid = aad_valid && feed_ok;
                mul_block = mask_block(aad_data, aad_keep);
            end
            phase_payload: begin
                mul_valid = hash_valid && feed_ok;
                mul_block = hash_block;
                hash_take = mul_valid;
            end
            phase_len: begin
                mul_valid = feed_ok;
                mul_block = {len_aad_q, len_pld_q};
            end
            default: begin
                mul_valid = 1'b0;
            end
        endcase
    end

    // ------------------------------
    // Phase machine
    // ------------------------------
    always_comb begin
        phase_next = phase;
        if (start_pulse) begin
            if (len_aad_bits != '0) begin
                phase_next = phase_aad;
            end else if (len_pld_bits != '0) begin
                phase_next = phase_payload;
            end else begin
                phase_next = phase_len;
            end
        end else begin
            case (phase)
                phase_idle: phase_next = phase_idle;
                phase_aad: begin
                    if (aad_last_fire) begin
                        phase_next = (len_pld_q != '0) ? phase_payload : phase_len;
                    end
                end
                phase_payload: begin
                    if (pld_drained) begin
                        phase_next = phase_len;
                    end
                end
                phase_len: begin
                    if (len_fire) begin
                        phase_next = phase_wait;
                    end
                end
                phase_wait: begin
                    if (mul_done) begin
                        phase_next = phase_done;
                    end
                end
                default: phase_next = phase_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= phase_idle;
        end else begin
            phase <= phase_next;
        end
    end

    // Done flags and tag capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aad_done          <= 1'b0;
            pld_done          <= 1'b0;
            lens_done         <= 1'b0;
            tag_pre_xor_valid <= 1'b0;
            tag_pre_xor       <= '0;
        end else if (start_pulse) begin
            aad_done          <= (len_aad_bits == '0);
            pld_done          <= (len_pld_bits == '0);
            lens_done         <= 1'b0;
            tag_pre_xor_valid <= 1'b0;
        end else begin
            if (aad_last_fire) begin
                aad_done <= 1'b1;
            end
            if (hash_take && hash_last) begin
                pld_done <= 1'b1;
            end
            if (len_fire) begin
                lens_done <= 1'b1;
            end
            // Only the lengths block multiply finishes in phase_wait
            if (phase == phase_wait && mul_done) begin
                tag_pre_xor       <= acc;
                tag_pre_xor_valid <= 1'b1;
            end
        end
    end

    a_phase_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(phase) && (phase inside {phase_idle, phase_aad, phase_payload,
                                             phase_len, phase_wait, phase_done})
    );

endmodule

// ==== logic/gcm_datapath_top.sv ====
module gcm_datapath_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            enc_mode,
    input  gcm_pkg::block_t hash_key,
    input  gcm_pkg::len_t   len_aad_bits,
    input  gcm_pkg::len_t   len_pld_bits,
    // AAD stream
    input  logic            aad_valid,
    output logic            aad_ready,
    input  logic            aad_last,
    input  gcm_pkg::block_t aad_data,
    input  gcm_pkg::keep_t  aad_keep,
    // Payload in, keystream rides along with each block
    input  logic            din_valid,
    output logic            din_ready,
    input  logic            din_last,
    input  gcm_pkg::block_t din_data,
    input  gcm_pkg::keep_t  din_keep,
    input  gcm_pkg::block_t ks_data,
    // Payload out
    output logic            dout_valid,
    input  logic            dout_ready,
    output logic            dout_last,
    output gcm_pkg::block_t dout_data,
    output gcm_pkg::keep_t  dout_keep,
    // Result and status
    output gcm_pkg::block_t tag_pre_xor,
    output logic            tag_pre_xor_valid,
    output logic            aad_done,
    output logic            pld_done,
    output logic            lens_done
);
    import gcm_pkg::*;

    logic   pld_open;
    logic   hash_valid;
    logic   hash_last;
    logic   hash_take;
    logic   init;
    logic   mul_valid;
    logic   mul_ready;
    logic   mul_done;
    block_t hash_block;
    block_t mul_block;
    block_t acc;

    // ------------------------------
    // Sequencer
    // ------------------------------
    gcm_sequencer u_gcm_sequencer (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .len_aad_bits      (len_aad_bits),
        .len_pld_bits      (len_pld_bits),
        .aad_valid         (aad_valid),
        .aad_ready         (aad_ready),
        .aad_last          (aad_last),
        .aad_data          (aad_data),
        .aad_keep          (aad_keep),
        .pld_open          (pld_open),
        .hash_valid        (hash_valid),
        .hash_block        (hash_block),
        .hash_last         (hash_last),
        .hash_take         (hash_take),
        .dout_valid        (dout_valid),
        .init              (init),
        .mul_valid         (mul_valid),
        .mul_block         (mul_block),
        .mul_ready         (mul_ready),
        .mul_done          (mul_done),
        .acc               (acc),
        .tag_pre_xor       (tag_pre_xor),
        .tag_pre_xor_valid (tag_pre_xor_valid),
        .aad_done          (aad_done),
        .pld_done          (pld_done),
        .lens_done         (lens_done)
    );

    // ------------------------------
    // Payload XOR and GHASH side by side
    // ------------------------------
    payload_ctr u_payload_ctr (
        .clk        (clk),
        .rst_n      (rst_n),
        .enc_mode   (enc_mode),
        .pld_open   (pld_open),
        .din_valid  (din_valid),
        .din_ready  (din_ready),
        .din_last   (din_last),
        .din_data   (din_data),
        .din_keep   (din_keep),
        .ks_data    (ks_data),
        .dout_valid (dout_valid),
        .dout_ready (dout_ready),
        .dout_last  (dout_last),
        .dout_data  (dout_data),
        .dout_keep  (dout_keep),
        .hash_valid (hash_valid),
        .hash_block (hash_block),
        .hash_last  (hash_last),
        .hash_take  (hash_take)
    );

    ghash_mult u_ghash_mult (
        .clk       (clk),
        .rst_n     (rst_n),
        .init      (init),
        .hash_key  (hash_key),
        .mul_valid (mul_valid),
        .mul_block (mul_block),
        .mul_ready (mul_ready),
        .mul_done  (mul_done),
        .acc       (acc)
    );

endmodule

// ==== include/gcm_ref_model.svh ====
`ifndef GCM_REF_MODEL_SVH
`define GCM_REF_MODEL_SVH

// ------------------------------
// GHASH reference model
// ------------------------------

// Product in GF(2^128), bit 127 of a vector is the x^0 coefficient
function automatic logic [127:0] gf128_mul(input logic [127:0] x, input logic [127:0] y);
    logic [127:0] z;
    logic [127:0] v;
    logic         carry;
    z = '0;
    v = y;
    for (int i = 0; i < 128; i++) begin
        if (x[127 - i]) begin
            z = z ^ v;
        end
        carry = v[0];
        v = v >> 1;
        // Reduce by x^128 + x^7 + x^2 + x + 1
        if (carry) begin
            v[127:120] = v[127:120] ^ 8'he1;
        end
    end
    return z;
endfunction

// Bytes with a clear keep bit become zero, keep bit b covers bits [8b+7:8b]
function automatic logic [127:0] apply_keep(input logic [127:0] data, input logic [15:0] keep);
    logic [127:0] res;
    for (int b = 0; b < 16; b++) begin
        res[b*8 +: 8] = keep[b] ? data[b*8 +: 8] : 8'h00;
    end
    return res;
endfunction

// One GHASH step
function automatic logic [127:0] ghash_fold(input logic [127:0] acc, input logic [127:0] blk,
                                            input logic [127:0] h);
    return gf128_mul(acc ^ blk, h);
endfunction

// AAD bit length on top, payload bit length below
function automatic logic [127:0] lengths_block(input logic [63:0] aad_bits,
                                               input logic [63:0] pld_bits);
    return {aad_bits, pld_bits};
endfunction

// GHASH always sees ciphertext
function automatic logic [127:0] hashed_block(input logic enc, input logic [127:0] din,
                                              input logic [127:0] ks, input logic [15:0] keep);
    if (enc) begin
        return apply_keep(din ^ ks, keep);
    end
    return apply_keep(din, keep);
endfunction

`endif

// ==== verif/gcm_tb.sv ====
module gcm_tb;

    localparam int NUM_MSGS   = 12;
    localparam int WAIT_LIMIT = 2000;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic         enc_mode;
    logic [127:0] hash_key;
    logic [63:0]  len_aad_bits;
    logic [63:0]  len_pld_bits;
    logic         aad_valid;
    logic         aad_ready;
    logic         aad_last;
    logic [127:0] aad_data;
    logic [15:0]  aad_keep;
    logic         din_valid;
    logic         din_ready;
    logic         din_last;
    logic [127:0] din_data;
    logic [15:0]  din_keep;
    logic [127:0] ks_data;
    logic         dout_valid;
    logic         dout_ready;
    logic         dout_last;
    logic [127:0] dout_data;
    logic [15:0]  dout_keep;
    logic [127:0] tag_pre_xor;
    logic         tag_pre_xor_valid;
    logic         aad_done;
    logic         pld_done;
    logic         lens_done;

    // Current message
    integer       seed;
    int           n_aad;
    int           n_pld;
    logic         msg_enc;
    logic [127:0] h_msg;
    logic [63:0]  aad_bits_msg;
    logic [63:0]  pld_bits_msg;
    logic [127:0] aad_blk [0:3];
    logic [15:0]  aad_kp  [0:3];
    logic [127:0] pld_blk [0:4];
    logic [127:0] ks_blk  [0:4];
    logic [15:0]  pld_kp  [0:4];

    `include "gcm_ref_model.svh"

    gcm_datapath_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // Error reporting and checks
    // ------------------------------
    task automatic stop_with_error(input string line);
        $display("** FAIL **");
        $display("%s", line);
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] got);
        stop_with_error($sformatf("Fail at time %0t: %s expected %0h got %0h",
                                  $time, name, exp, got));
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] got);
        assert (got === exp) else report_mismatch(name, exp, got);
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        assert (got === exp) else report_mismatch(name, 128'(exp), 128'(got));
    endtask

    // ------------------------------
    // Random message contents
    // ------------------------------
    function automatic int rand_below(input int n);
        return int'(($random(seed) & 32'h7fff_ffff) % n);
    endfunction

    function automatic logic [127:0] rand_block();
        logic [127:0] blk;
        for (int w = 0; w < 4; w++) begin
            blk[w*32 +: 32] = $random(seed);
        end
        return blk;
    endfunction

    // At least one byte stays valid in a last block
    function automatic logic [15:0] rand_keep();
        logic [15:0] k;
        k = 16'($random(seed));
        if (k == 16'h0) begin
            k = 16'h8000;
        end
        return k;
    endfunction

    function automatic logic [63:0] bit_length(input int n, input logic [15:0] last_keep);
        if (n == 0) begin
            return 64'd0;
        end
        return 64'((n - 1) * 128 + $countones(last_keep) * 8);
    endfunction

    function automatic logic [127:0] expected_tag();
        logic [127:0] acc;
        acc = '0;
        for (int i = 0; i < n_aad; i++) begin
            acc = ghash_fold(acc, apply_keep(aad_blk[i], aad_kp[i]), h_msg);
        end
        for (int i = 0; i < n_pld; i++) begin
            acc = ghash_fold(acc, hashed_block(msg_enc, pld_blk[i], ks_blk[i], pld_kp[i]), h_msg);
        end
        return ghash_fold(acc, lengths_block(aad_bits_msg, pld_bits_msg), h_msg);
    endfunction

    // Message 0 is empty and messages 1 and 2 force encrypt and decrypt with payload
    task automatic make_message(input int m);
        n_aad   = (m == 0) ? 0 : rand_below(5);
        n_pld   = (m == 0) ? 0 : (m <= 2) ? 1 + rand_below(5) : rand_below(6);
        msg_enc = (m == 1) ? 1'b1 : (m == 2) ? 1'b0 : (rand_below(2) == 1);
        h_msg   = rand_block();
        for (int i = 0; i < n_aad; i++) begin
            aad_blk[i] = rand_block();
            aad_kp[i]  = (i == n_aad - 1) ? rand_keep() : 16'hffff;
        end
        for (int i = 0; i < n_pld; i++) begin
            pld_blk[i] = rand_block();
            ks_blk[i]  = rand_block();
            pld_kp[i]  = (i == n_pld - 1) ? rand_keep() : 16'hffff;
        end
        aad_bits_msg = (n_aad == 0) ? 64'd0 : bit_length(n_aad, aad_kp[n_aad - 1]);
        pld_bits_msg = (n_pld == 0) ? 64'd0 : bit_length(n_pld, pld_kp[n_pld - 1]);
    endtask

    // ------------------------------
    // Drivers and output collector
    // ------------------------------
    task automatic send_aad();
        int cnt;
        for (int i = 0; i < n_aad; i++) begin
            aad_valid <= 1'b1;
            aad_data  <= aad_blk[i];
            aad_keep  <= aad_kp[i];
            aad_last  <= (i == n_aad - 1);
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                assert (cnt < WAIT_LIMIT) else stop_with_error("Timed out waiting for aad_ready");
            end while (!(aad_valid && aad_ready));
        end
        aad_valid <= 1'b0;
        aad_last  <= 1'b0;
    endtask

    task automatic send_payload();
        int cnt;
        for (int i = 0; i < n_pld; i++) begin
            din_valid <= 1'b1;
            din_data  <= pld_blk[i];
            ks_data   <= ks_blk[i];
            din_keep  <= pld_kp[i];
            din_last  <= (i == n_pld - 1);
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                assert (cnt < WAIT_LIMIT) else stop_with_error("Timed out waiting for din_ready");
            end while (!(din_valid && din_ready));
        end
        din_valid <= 1'b0;
        din_last  <= 1'b0;
    endtask

    task automatic collect_dout();
        int           idx;
        int           cnt;
        int           stall;
        logic         held;
        logic [127:0] held_data;
        idx   = 0;
        cnt   = 0;
        stall = 0;
        held  = 1'b0;
        while (idx < n_pld) begin
            @(posedge clk);
            cnt++;
            assert (cnt < WAIT_LIMIT) else stop_with_error("Timed out waiting for dout_valid");
            // A stalled block must still be there unchanged
            if (held) begin
                assert (dout_valid) else stop_with_error("dout_valid dropped without dout_ready");
                check_value("dout_data while stalled", held_data, dout_data);
            end
            held      = dout_valid && !dout_ready;
            held_data = dout_data;
            if (dout_valid && dout_ready) begin
                check_value("dout_data", apply_keep(pld_blk[idx] ^ ks_blk[idx], pld_kp[idx]),
                            dout_data);
                check_value("dout_keep", 128'(pld_kp[idx]), 128'(dout_keep));
                check_flag("dout_last", idx == n_pld - 1, dout_last);
                idx++;
                cnt = 0;
            end
            // Random stretches of back-pressure
            if (stall > 0) begin
                stall--;
                dout_ready <= 1'b0;
            end else if (rand_below(4) == 0) begin
                stall = rand_below(12);
                dout_ready <= 1'b0;
            end else begin
                dout_ready <= 1'b1;
            end
        end
        dout_ready <= 1'b1;
    endtask

    task automatic run_message();
        logic [127:0] exp_tag;
        int           cnt;
        exp_tag = expected_tag();
        start        <= 1'b1;
        enc_mode     <= msg_enc;
        hash_key     <= h_msg;
        len_aad_bits <= aad_bits_msg;
        len_pld_bits <= pld_bits_msg;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        check_flag("tag_pre_xor_valid", 1'b0, tag_pre_xor_valid);
        check_flag("lens_done", 1'b0, lens_done);
        check_flag("aad_done", n_aad == 0, aad_done);
        check_flag("pld_done", n_pld == 0, pld_done);
        fork
            send_aad();
            send_payload();
            collect_dout();
        join
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
            assert (cnt < WAIT_LIMIT) else stop_with_error("Timed out waiting for the tag");
            assert (!dout_valid) else stop_with_error("An extra payload block came out");
        end while (!tag_pre_xor_valid);
        check_flag("aad_done", 1'b1, aad_done);
        check_flag("pld_done", 1'b1, pld_done);
        check_flag("lens_done", 1'b1, lens_done);
        check_value("tag_pre_xor", exp_tag, tag_pre_xor);
        repeat (rand_below(4)) @(posedge clk);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        seed = 60;
        rst_n        <= 1'b0;
        start        <= 1'b0;
        enc_mode     <= 1'b0;
        hash_key     <= '0;
        len_aad_bits <= '0;
        len_pld_bits <= '0;
        aad_valid    <= 1'b0;
        aad_last     <= 1'b0;
        aad_data     <= '0;
        aad_keep     <= '0;
        din_valid    <= 1'b0;
        din_last     <= 1'b0;
        din_data     <= '0;
        din_keep     <= '0;
        ks_data      <= '0;
        dout_ready   <= 1'b1;

        // Model self check against GCM test case 2 with a zero key
        check_value("model GHASH",
                    128'hf38cbb1ad69223dcc3457ae5b6b0f885,
                    ghash_fold(ghash_fold('0, 128'h0388dace60b6a392f328c2b971b2fe78,
                                          128'h66e94bd4ef8a2c3b884cfa59ca342b2e),
                               128'h80, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e));

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_flag("aad_ready", 1'b0, aad_ready);
        check_flag("din_ready", 1'b0, din_ready);
        check_flag("dout_valid", 1'b0, dout_valid);
        check_flag("tag_pre_xor_valid", 1'b0, tag_pre_xor_valid);
        check_flag("aad_done", 1'b0, aad_done);
        check_flag("pld_done", 1'b0, pld_done);
        check_flag("lens_done", 1'b0, lens_done);

        for (int m = 0; m < NUM_MSGS; m++) begin
            make_message(m);
            run_message();
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
logic/gcm_pkg.sv
logic/ghash_mult.sv
logic/payload_ctr.sv
logic/gcm_sequencer.sv
logic/gcm_datapath_top.sv
verif/gcm_tb.sv

// ==== Makefile ====
OBJ := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/Vgcm_tb: sources.f logic/*.sv verif/*.sv include/*.svh
	verilator --binary --timing --assert -j 0 -f sources.f --top-module gcm_tb -Mdir $(OBJ)

# The log decides pass or fail, grep returns non-zero without the pass line
run: $(OBJ)/Vgcm_tb
	./$(OBJ)/Vgcm_tb | tee run.log
	grep -qF '** PASS **' run.log

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module gcm_tb

clean:
	rm -rf $(OBJ) run.log
